/* rv_pkg.sv */
package rv_pkg;

    localparam int XLEN      = 32;
    localparam int ILEN      = 32;  // Instruction word width.
    localparam int REG_IDX_W = 5;

    // Major opcodes handled by the execute slice.
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_LUI = 4'd0,
        ALU_ADD = 4'd1,
        ALU_SUB = 4'd2,
        ALU_MUL = 4'd3,
        ALU_AND = 4'd4,
        ALU_OR  = 4'd5,
        ALU_XOR = 4'd6,
        ALU_SLL = 4'd7,
        ALU_SRL = 4'd8,
        ALU_SRA = 4'd9,
        ALU_SLT = 4'd10,
        ALU_BEQ = 4'd11,
        ALU_BNE = 4'd12,
        ALU_BGE = 4'd13,
        ALU_BLT = 4'd14
    } alu_op_t;

    // funct3 encodings for OP and OP-IMM.
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 encodings for BRANCH.
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_MUL     = 7'b0000001;  // M extension group.
    localparam int         F7_ALT_BIT = 5;           // SUB and SRA select.

endpackage

/* id_decode.sv */
`timescale 1ns/1ns

module id_decode (
    input  logic [rv_pkg::ILEN-1:0]      instr,
    output logic [rv_pkg::REG_IDX_W-1:0] rs1,
    output logic [rv_pkg::REG_IDX_W-1:0] rs2,
    output logic [rv_pkg::REG_IDX_W-1:0] rd,
    output logic [rv_pkg::XLEN-1:0]      imm,
    output logic                         use_imm,
    output rv_pkg::alu_op_t              alu_op,
    output logic                         is_signed,
    output logic                         writes_rd
);

    rv_pkg::opcode_t         opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic                    alt;
    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_u;
    logic [rv_pkg::XLEN-1:0] imm_b;

    // Shared funct3 mapping of OP and OP-IMM.
    function automatic rv_pkg::alu_op_t alu_from_f3(
        input logic [2:0] f3,
        input logic       f_alt
    );
        case (f3)
            rv_pkg::F3_ADD:  return f_alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            rv_pkg::F3_SLL:  return rv_pkg::ALU_SLL;
            rv_pkg::F3_SLT,
            rv_pkg::F3_SLTU: return rv_pkg::ALU_SLT;
            rv_pkg::F3_XOR:  return rv_pkg::ALU_XOR;
            rv_pkg::F3_SR:   return f_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            rv_pkg::F3_OR:   return rv_pkg::ALU_OR;
            default:         return rv_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode = rv_pkg::opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign alt    = funct7[rv_pkg::F7_ALT_BIT];

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        imm       = imm_i;
        use_imm   = 1'b0;
        alu_op    = rv_pkg::ALU_ADD;  // Unknown encodings add and drop the result.
        is_signed = 1'b1;
        writes_rd = 1'b0;
        case (opcode)
            rv_pkg::OP_REG: begin
                if (funct7 == rv_pkg::F7_MUL) begin
                    // Only the low product word is supported.
                    if (funct3 == rv_pkg::F3_ADD) begin
                        alu_op    = rv_pkg::ALU_MUL;
                        writes_rd = 1'b1;
                    end
                end else begin
                    alu_op    = alu_from_f3(funct3, alt);
                    is_signed = (funct3 != rv_pkg::F3_SLTU);
                    writes_rd = 1'b1;
                end
            end
            rv_pkg::OP_IMM: begin
                use_imm   = 1'b1;
                alu_op    = alu_from_f3(funct3, alt && (funct3 == rv_pkg::F3_SR)); // No SUBI.
                is_signed = (funct3 != rv_pkg::F3_SLTU);
                writes_rd = 1'b1;
            end
            rv_pkg::OP_LUI: begin
                imm       = imm_u;
                use_imm   = 1'b1;
                alu_op    = rv_pkg::ALU_LUI;
                writes_rd = 1'b1;
            end
            rv_pkg::OP_BRANCH: begin
                imm = imm_b;
                case (funct3)
                    rv_pkg::F3_BEQ:  alu_op = rv_pkg::ALU_BEQ;
                    rv_pkg::F3_BNE:  alu_op = rv_pkg::ALU_BNE;
                    rv_pkg::F3_BLT:  alu_op = rv_pkg::ALU_BLT;
                    rv_pkg::F3_BGE:  alu_op = rv_pkg::ALU_BGE;
                    rv_pkg::F3_BLTU: begin
                        alu_op    = rv_pkg::ALU_BLT;
                        is_signed = 1'b0;
                    end
                    rv_pkg::F3_BGEU: begin
                        alu_op    = rv_pkg::ALU_BGE;
                        is_signed = 1'b0;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

/* reg_file.sv */
`timescale 1ns/1ns

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [rv_pkg::REG_IDX_W-1:0] ra1,
    input  logic [rv_pkg::REG_IDX_W-1:0] ra2,
    output logic [rv_pkg::XLEN-1:0]      rd1,
    output logic [rv_pkg::XLEN-1:0]      rd2,
    input  logic                         we,
    input  logic [rv_pkg::REG_IDX_W-1:0] wa,
    input  logic [rv_pkg::XLEN-1:0]      wd
);

    logic [rv_pkg::XLEN-1:0] regs [NUM_REGS];
    logic                    wr_ok;

    // x0 and indices past the profile size are never written.
    assign wr_ok = we && (wa != '0) && (wa < NUM_REGS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wa] <= wd;
        end
    end

    function automatic logic [rv_pkg::XLEN-1:0] read_port(
        input logic [rv_pkg::REG_IDX_W-1:0] ra
    );
        if ((ra == '0) || (ra >= NUM_REGS)) return '0;
        else if (wr_ok && (wa == ra))       return wd;  // Write-through.
        else                                return regs[ra];
    endfunction

    always_comb begin
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
    end

endmodule

/* operand_fetch.sv */
`timescale 1ns/1ns

module operand_fetch #(
    parameter int NUM_REGS = 32
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         instr_valid,
    input  logic [rv_pkg::REG_IDX_W-1:0] rs1,
    input  logic [rv_pkg::REG_IDX_W-1:0] rs2,
    input  logic [rv_pkg::REG_IDX_W-1:0] rd,
    input  logic [rv_pkg::XLEN-1:0]      imm,
    input  logic                         use_imm,
    input  rv_pkg::alu_op_t              alu_op,
    input  logic                         is_signed,
    input  logic                         writes_rd,
    input  logic [rv_pkg::XLEN-1:0]      fwd_data,
    input  logic                         wb_en,
    input  logic [rv_pkg::REG_IDX_W-1:0] wb_rd,
    input  logic [rv_pkg::XLEN-1:0]      wb_data,
    output logic                         ex_valid,
    output logic [rv_pkg::XLEN-1:0]      ex_a,
    output logic [rv_pkg::XLEN-1:0]      ex_b,
    output rv_pkg::alu_op_t              ex_op,
    output logic                         ex_signed,
    output logic [rv_pkg::REG_IDX_W-1:0] ex_rd,
    output logic                         ex_wr
);

    logic [rv_pkg::XLEN-1:0] rf_rd1;
    logic [rv_pkg::XLEN-1:0] rf_rd2;
    logic [rv_pkg::XLEN-1:0] src1;
    logic [rv_pkg::XLEN-1:0] src2;
    logic                    ex_hit;

    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) i_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (rs1),
        .ra2   (rs2),
        .rd1   (rf_rd1),
        .rd2   (rf_rd2),
        .we    (wb_en),
        .wa    (wb_rd),
        .wd    (wb_data)
    );

    // Instruction in execute will write a real register.
    assign ex_hit = ex_valid && ex_wr && (ex_rd != '0) && (ex_rd < NUM_REGS);

    assign src1 = (ex_hit && (ex_rd == rs1)) ? fwd_data : rf_rd1;
    assign src2 = (ex_hit && (ex_rd == rs2)) ? fwd_data : rf_rd2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            ex_wr    <= 1'b0;
        end else begin
            ex_valid <= instr_valid;
            ex_wr    <= instr_valid && writes_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            ex_a      <= src1;
            ex_b      <= use_imm ? imm : src2;
            ex_op     <= alu_op;
            ex_signed <= is_signed;
            ex_rd     <= rd;
        end
    end

endmodule

/* ex_alu.sv */
`timescale 1ns/1ns

module ex_alu (
    input  logic                    is_signed,
    input  logic [rv_pkg::XLEN-1:0] a,
    input  logic [rv_pkg::XLEN-1:0] b,
    input  rv_pkg::alu_op_t         op,
    output logic                    branch,  // 1: taken.
    output logic [rv_pkg::XLEN-1:0] result
);

    function automatic logic less_than(
        input logic                    sgn,
        input logic [rv_pkg::XLEN-1:0] in_a,
        input logic [rv_pkg::XLEN-1:0] in_b
    );
        if (sgn) return $signed(in_a) < $signed(in_b);
        else     return in_a < in_b;
    endfunction

    function automatic logic [rv_pkg::XLEN-1:0] arith(
        input rv_pkg::alu_op_t         in_op,
        input logic                    sgn,
        input logic [rv_pkg::XLEN-1:0] in_a,
        input logic [rv_pkg::XLEN-1:0] in_b
    );
        logic signed [rv_pkg::XLEN-1:0] s_a;
        logic [4:0]                     shamt;

        s_a   = in_a;
        shamt = in_b[4:0];
        case (in_op)
            rv_pkg::ALU_LUI: return in_b;
            rv_pkg::ALU_ADD: return in_a + in_b;
            rv_pkg::ALU_SUB: return in_a - in_b;
            rv_pkg::ALU_MUL: return in_a * in_b;  // Low word only.
            rv_pkg::ALU_AND: return in_a & in_b;
            rv_pkg::ALU_OR:  return in_a | in_b;
            rv_pkg::ALU_XOR: return in_a ^ in_b;
            rv_pkg::ALU_SLL: return in_a << shamt;
            rv_pkg::ALU_SRL: return in_a >> shamt;
            rv_pkg::ALU_SRA: return s_a >>> shamt;
            rv_pkg::ALU_SLT: return {{(rv_pkg::XLEN-1){1'b0}}, less_than(sgn, in_a, in_b)};
            default:         return in_a + in_b;
        endcase
    endfunction

    function automatic logic compare(
        input rv_pkg::alu_op_t         in_op,
        input logic                    sgn,
        input logic [rv_pkg::XLEN-1:0] in_a,
        input logic [rv_pkg::XLEN-1:0] in_b
    );
        case (in_op)
            rv_pkg::ALU_BEQ: return in_a == in_b;
            rv_pkg::ALU_BNE: return in_a != in_b;
            rv_pkg::ALU_BGE: return !less_than(sgn, in_a, in_b);
            rv_pkg::ALU_BLT: return less_than(sgn, in_a, in_b);
            default:         return 1'b0;  // Not a branch.
        endcase
    endfunction

    assign result = arith(op, is_signed, a, b);
    assign branch = compare(op, is_signed, a, b);

endmodule

/* ex_writeback.sv */
`timescale 1ns/1ns

module ex_writeback (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         ex_valid,
    input  logic                         ex_wr,
    input  logic [rv_pkg::REG_IDX_W-1:0] ex_rd,
    input  logic [rv_pkg::XLEN-1:0]      alu_result,
    input  logic                         alu_branch,
    output logic [rv_pkg::XLEN-1:0]      result,
    output logic                         branch_taken,
    output logic                         result_valid,
    output logic                         wb_en,
    output logic [rv_pkg::REG_IDX_W-1:0] wb_rd,
    output logic [rv_pkg::XLEN-1:0]      wb_data
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            branch_taken <= 1'b0;
            wb_en        <= 1'b0;
        end else begin
            result_valid <= ex_valid;
            branch_taken <= ex_valid && alu_branch;
            wb_en        <= ex_valid && ex_wr && (ex_rd != '0);  // Drop x0 writes.
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            result <= alu_result;
            wb_rd  <= ex_rd;
        end
    end

    // Register file takes the same word that leaves on the result port.
    assign wb_data = result;

endmodule

/* alu_core_top.sv */
`timescale 1ns/1ns

module alu_core_top #(
    parameter int NUM_REGS = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [rv_pkg::ILEN-1:0] instr,
    input  logic                    instr_valid,
    output logic [rv_pkg::XLEN-1:0] result,
    output logic                    branch_taken,
    output logic                    result_valid
);

    logic [rv_pkg::REG_IDX_W-1:0] rs1;
    logic [rv_pkg::REG_IDX_W-1:0] rs2;
    logic [rv_pkg::REG_IDX_W-1:0] rd;
    logic [rv_pkg::XLEN-1:0]      imm;
    logic                         use_imm;
    rv_pkg::alu_op_t              alu_op;
    logic                         is_signed;
    logic                         writes_rd;

    logic                         ex_valid;
    logic [rv_pkg::XLEN-1:0]      ex_a;
    logic [rv_pkg::XLEN-1:0]      ex_b;
    rv_pkg::alu_op_t              ex_op;
    logic                         ex_signed;
    logic [rv_pkg::REG_IDX_W-1:0] ex_rd;
    logic                         ex_wr;

    logic [rv_pkg::XLEN-1:0]      alu_result;
    logic                         alu_branch;

    logic                         wb_en;
    logic [rv_pkg::REG_IDX_W-1:0] wb_rd;
    logic [rv_pkg::XLEN-1:0]      wb_data;

    id_decode i_id_decode (
        .instr     (instr),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .use_imm   (use_imm),
        .alu_op    (alu_op),
        .is_signed (is_signed),
        .writes_rd (writes_rd)
    );

    operand_fetch #(
        .NUM_REGS (NUM_REGS)
    ) i_operand_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .use_imm     (use_imm),
        .alu_op      (alu_op),
        .is_signed   (is_signed),
        .writes_rd   (writes_rd),
        .fwd_data    (alu_result),  // Bypass from execute.
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .ex_valid    (ex_valid),
        .ex_a        (ex_a),
        .ex_b        (ex_b),
        .ex_op       (ex_op),
        .ex_signed   (ex_signed),
        .ex_rd       (ex_rd),
        .ex_wr       (ex_wr)
    );

    ex_alu i_ex_alu (
        .is_signed (ex_signed),
        .a         (ex_a),
        .b         (ex_b),
        .op        (ex_op),
        .branch    (alu_branch),
        .result    (alu_result)
    );

    ex_writeback i_ex_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_valid     (ex_valid),
        .ex_wr        (ex_wr),
        .ex_rd        (ex_rd),
        .alu_result   (alu_result),
        .alu_branch   (alu_branch),
        .result       (result),
        .branch_taken (branch_taken),
        .result_valid (result_valid),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 16,
    parameter int DRIVE_DELAY  = 1
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;  // Released off the edge like all other inputs.
    end

endmodule

/* tb_checker.sv */
`timescale 1ns/1ns

module tb_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    instr_valid,
    input  int                      vec_idx,
    input  logic [rv_pkg::XLEN-1:0] exp_result,
    input  logic                    exp_branch,
    input  logic [rv_pkg::XLEN-1:0] result,
    input  logic                    branch_taken,
    input  logic                    result_valid,
    input  logic                    end_of_test,
    output int                      value_errors,
    output int                      protocol_errors,
    output int                      pending
);

    // Entry layout is {vector index, result, branch flag}.
    logic [64:0] expected_q [$];
    logic [64:0] entry;
    logic [1:0]  issue_hist;

    initial begin
        value_errors    = 0;
        protocol_errors = 0;
        pending         = 0;
        issue_hist      = 2'b00;
    end

    // Sampled at the falling edge, after the drive delay and before the next DUT edge.
    always @(negedge clk) begin
        if ($time == 0) begin
            issue_hist = 2'b00;  // Power-up transition of clk.
        end else if (!rst_n) begin
            if (result_valid !== 1'b0) begin
                $display("result_valid is not low during reset at %0t.", $time);
                protocol_errors++;
            end
            issue_hist = 2'b00;
        end else begin
            if (result_valid !== issue_hist[1]) begin
                $display("result_valid is %b at %0t, but an issue two cycles earlier was %b.",
                         result_valid, $time, issue_hist[1]);
                protocol_errors++;
            end
            if (result_valid === 1'b1) begin
                if (expected_q.size() == 0) begin
                    $display("result_valid at %0t with no instruction outstanding.", $time);
                    protocol_errors++;
                end else begin
                    entry = expected_q.pop_front();
                    if (result !== entry[32:1]) begin
                        $display("[ERROR] vector %0d result: expected %h, actual %h",
                                 entry[64:33], entry[32:1], result);
                        value_errors++;
                    end
                    if (branch_taken !== entry[0]) begin
                        $display("[ERROR] vector %0d branch_taken: expected %b, actual %b",
                                 entry[64:33], entry[0], branch_taken);
                        value_errors++;
                    end
                end
            end
            if (instr_valid === 1'b1) begin
                expected_q.push_back({vec_idx[31:0], exp_result, exp_branch});
            end
            issue_hist = {issue_hist[0], instr_valid === 1'b1};
        end
        pending = expected_q.size();
    end

    always @(posedge end_of_test) begin
        if (expected_q.size() != 0) begin
            $display("%0d expected results never arrived.", expected_q.size());
            protocol_errors++;
        end
    end

endmodule

/* tb_alu_core.sv */
`timescale 1ns/1ns

module tb_alu_core;

    localparam int MAX_VECS      = 64;
    localparam int DRIVE_DELAY   = 1;
    localparam int RESET_TIMEOUT = 100;
    localparam int DRAIN_TIMEOUT = 20;

    logic                    clk;
    logic                    rst_n;
    logic [rv_pkg::ILEN-1:0] instr;
    logic                    instr_valid;
    logic [rv_pkg::XLEN-1:0] result;
    logic                    branch_taken;
    logic                    result_valid;
    logic [rv_pkg::XLEN-1:0] exp_result;
    logic                    exp_branch;
    int                      vec_idx;
    logic                    end_of_test;
    int                      value_errors;
    int                      protocol_errors;
    int                      pending;
    int                      timeout_errors;
    logic [31:0]             lfsr;

    // {instr, expected result, gap code nibble, branch nibble}.
    logic [71:0] vectors [MAX_VECS];

    tb_clock_gen #(
        .PERIOD_NS    (4),
        .RESET_CYCLES (16),
        .DRIVE_DELAY  (DRIVE_DELAY)
    ) i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    alu_core_top #(
        .NUM_REGS (32)
    ) i_alu_core_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .result       (result),
        .branch_taken (branch_taken),
        .result_valid (result_valid)
    );

    tb_checker i_checker (
        .clk             (clk),
        .rst_n           (rst_n),
        .instr_valid     (instr_valid),
        .vec_idx         (vec_idx),
        .exp_result      (exp_result),
        .exp_branch      (exp_branch),
        .result          (result),
        .branch_taken    (branch_taken),
        .result_valid    (result_valid),
        .end_of_test     (end_of_test),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .pending         (pending)
    );

    // Fibonacci LFSR, taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_gap(output int gap);
        logic [1:0] bits;
        lfsr    = lfsr_next(lfsr);
        bits[0] = lfsr[0];
        lfsr    = lfsr_next(lfsr);
        bits[1] = lfsr[0];
        gap     = bits;
    endtask

    initial begin : main
        int gap;
        int cycles;
        int n;

        instr          = '0;
        instr_valid    = 1'b0;
        exp_result     = '0;
        exp_branch     = 1'b0;
        vec_idx        = 0;
        end_of_test    = 1'b0;
        timeout_errors = 0;
        lfsr           = 32'he5b3_6cec;
        $readmemh("alu_vectors.txt", vectors);

        cycles = 0;
        while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout waiting for reset release.");
            timeout_errors++;
        end else begin
            n = 0;
            // Words are OP_REG, OP_IMM, OP_LUI and OP_BRANCH encodings.
            while (n < MAX_VECS && !$isunknown(vectors[n])) begin
                if (vectors[n][7:4] == 4'd0) random_gap(gap);
                else                         gap = vectors[n][7:4] - 1;
                repeat (gap) begin
                    @(posedge clk);
                    #DRIVE_DELAY;
                    instr_valid = 1'b0;
                end
                @(posedge clk);
                #DRIVE_DELAY;
                instr       = vectors[n][71:40];
                exp_result  = vectors[n][39:8];
                exp_branch  = vectors[n][0];
                vec_idx     = n;
                instr_valid = 1'b1;
                n++;
            end
            @(posedge clk);
            #DRIVE_DELAY;
            instr_valid = 1'b0;
            $display("Issued %0d vectors.", n);
        end

        cycles = 0;
        while (pending != 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (pending != 0) begin
            $display("Timeout waiting for %0d outstanding results.", pending);
            timeout_errors++;
        end
        repeat (4) @(posedge clk);  // Idle tail, any stray result_valid shows here.
        end_of_test = 1'b1;
        #1;

        $display("Errors: %0d value, %0d protocol, %0d timeout.",
                 value_errors, protocol_errors, timeout_errors);
        if (value_errors + protocol_errors + timeout_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* alu_vectors.txt */
// Columns: instruction word _ expected result _ gap code and branch flag.
// Gap code 0 picks an LFSR gap, n > 0 forces n-1 idle cycles before issue.
00a00093_0000000a_00  // ADDI  x1, x0, 10
ffd00113_fffffffd_00  // ADDI  x2, x0, -3
123451b7_12345000_00  // LUI   x3, 0x12345
00208233_00000007_00  // ADD   x4, x1, x2
402082b3_0000000d_00  // SUB   x5, x1, x2
02208333_ffffffe2_00  // MUL   x6, x1, x2
0011e3b3_1234500a_00  // OR    x7, x3, x1
0023f433_12345008_10  // AND   x8, x7, x2     back to back
001444b3_12345002_10  // XOR   x9, x8, x1     back to back
00109533_00002800_00  // SLL   x10, x1, x1
001155b3_003fffff_00  // SRL   x11, x2, x1
40115633_ffffffff_00  // SRA   x12, x2, x1
001126b3_00000001_00  // SLT   x13, x2, x1
00113733_00000000_00  // SLTU  x14, x2, x1
0ff3f793_0000000a_00  // ANDI  x15, x7, 0xff
f000e813_ffffff0a_00  // ORI   x16, x1, -256
fff14893_00000002_00  // XORI  x17, x2, -1
00409913_000000a0_00  // SLLI  x18, x1, 4
01c15993_0000000f_00  // SRLI  x19, x2, 28
40115a13_fffffffe_00  // SRAI  x20, x2, 1
ffe12a93_00000001_00  // SLTI  x21, x2, -2
fff0bb13_00000001_00  // SLTIU x22, x1, -1
00108063_00000014_01  // BEQ   x1, x1
00209063_00000007_01  // BNE   x1, x2
00114063_00000007_01  // BLT   x2, x1
00115063_00000007_00  // BGE   x2, x1
00116063_00000007_00  // BLTU  x2, x1
00117063_00000007_01  // BGEU  x2, x1
00208463_00000007_00  // BEQ   x1, x2, +8     rd field is 8
00040b93_12345008_10  // ADDI  x23, x8, 0     x8 untouched
00508013_0000000f_00  // ADDI  x0, x1, 5      dropped
00100c33_0000000a_10  // ADD   x24, x0, x1
00000c93_00000000_20  // ADDI  x25, x0, 0
12300d13_00000123_00  // ADDI  x26, x0, 0x123
001d0d93_00000124_10  // ADDI  x27, x26, 1    back to back
01bd0e33_00000247_20  // ADD   x28, x26, x27  distance two
41ae0eb3_00000124_30  // SUB   x29, x28, x26  distance three
03ce8f33_000298fc_10  // MUL   x30, x29, x28
01df5063_00029a20_11  // BGE   x30, x29
ffffffb7_fffff000_10  // LUI   x31, 0xfffff
41afd0b3_fffffe00_10  // SRA   x1, x31, x26
00108133_fffffc00_10  // ADD   x2, x1, x1

/* sources.f */
rv_pkg.sv
id_decode.sv
reg_file.sv
operand_fetch.sv
ex_alu.sv
ex_writeback.sv
alu_core_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_alu_core.sv

/* Bender.yml */
package:
  name: alu_core

sources:
  - rv_pkg.sv
  - id_decode.sv
  - reg_file.sv
  - operand_fetch.sv
  - ex_alu.sv
  - ex_writeback.sv
  - alu_core_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_checker.sv
      - tb_alu_core.sv
